// File: src.f
mips_pkg.sv
stage_regs.sv
fetch_unit.sv
decoder.sv
reg_file.sv
hazard_unit.sv
alu.sv
wb_data_master.sv
mips_core.sv
tb_mips_core.sv

// File: Makefile
TOP := tb_mips_core

all: run

build:
	verilator --binary -j 0 --top-module $(TOP) -f src.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
  import mips_pkg::*;

  localparam int imem_depth = 256;
  localparam int addr_bits  = $clog2(imem_depth);
  localparam int body_len   = 40;
  localparam int halt_idx   = body_len + 31;  // beq $0,$0 spinning on itself
  localparam int dmem_words = 128;

  logic clk = 1'b0;
  logic rst_n, run, prog_we;
  logic wb_ack = 1'b0;
  logic [addr_bits-1:0] prog_addr;
  logic [data_width-1:0] prog_data;
  logic [data_width-1:0] wb_dat_r = '0;
  logic wb_cyc, wb_stb, wb_we;
  logic [data_width-1:0] wb_adr, wb_dat_w;

  logic [data_width-1:0] prog [imem_depth];
  logic [data_width-1:0] dmem [dmem_words];  // slave memory
  logic [data_width-1:0] exp_addr [$];
  logic [data_width-1:0] exp_data [$];
  logic ack_next = 1'b0;
  logic [data_width-1:0] rdata_next = '0;
  logic acc_open, pend, pend_we;
  logic [data_width-1:0] pend_adr, pend_dat;
  int ack_wait;
  int store_cnt = 0;

  mips_core UUT (
    .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data, .wb_dat_r, .wb_ack,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: wb_adr expected %h, got %h",
                          $time, expected, actual));
    end
  endtask

  task automatic check_data(input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t: wb_dat_w expected %h, got %h",
                          $time, expected, actual));
    end
  endtask

  function automatic logic [data_width-1:0] fill_word(input int idx);
    return (32'(idx) << 2) * 32'h9e37_79b9 + 32'h0bad_f00d;
  endfunction

  function automatic logic [data_width-1:0] r_word(input funct_t fn,
                                                   input logic [4:0] rs, rt, rd);
    return {op_special, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [data_width-1:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                                   input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic gen_program();
    funct_t fns [5];
    int kind, off;
    logic [4:0] rs, rt, rd;
    fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_slt};
    for (int i = 0; i < imem_depth; i++) begin
      prog[i] = '0;
    end
    for (int k = 0; k < body_len; k++) begin
      kind = $urandom_range(0, 9);
      rs   = 5'($urandom_range(0, 7));  // few registers, many dependencies
      rt   = 5'($urandom_range(0, 7));
      rd   = 5'($urandom_range(0, 7));
      case (kind)
        0, 1, 2, 3, 4: prog[k] = r_word(fns[kind], rs, rt, rd);
        5: prog[k] = i_word(op_addiu, rs, rt, 16'($urandom));
        6: prog[k] = i_word(op_lw, 5'd0, rt, 16'($urandom_range(0, 15) * 4));
        7: prog[k] = i_word(op_sw, 5'd0, rt, 16'($urandom_range(0, 15) * 4));
        8: begin
          off = $urandom_range(0, 3);
          if (off > body_len - 1 - k) off = body_len - 1 - k;  // stay inside the body
          prog[k] = i_word(op_beq, rs, rt, 16'(off));
        end
        default: prog[k] = i_word(6'h0f, rs, rt, 16'($urandom));  // lui, not supported
      endcase
    end
    for (int r = 1; r < 32; r++) begin
      prog[body_len + r - 1] = i_word(op_sw, 5'd0, 5'(r), 16'(32'h100 + 4 * r));
    end
    prog[halt_idx] = i_word(op_beq, 5'd0, 5'd0, 16'hffff);
  endtask

  // plain sequential ISA model, fills the expected store list
  task automatic run_model();
    logic [data_width-1:0] regs [32];
    logic [data_width-1:0] mem [dmem_words];
    logic [data_width-1:0] a, b, imm, adr;
    instr_t w;
    int pc, steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      mem[i] = fill_word(i);
    end
    pc = 0;
    steps = 0;
    while (pc != halt_idx) begin
      w   = prog[pc];
      a   = regs[w.i_fmt.rs];
      b   = regs[w.i_fmt.rt];
      imm = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
      adr = a + imm;
      pc++;
      case (w.i_fmt.opcode)
        op_special: begin
          case (w.r_fmt.funct)
            fn_addu: regs[w.r_fmt.rd] = a + b;
            fn_subu: regs[w.r_fmt.rd] = a - b;
            fn_and:  regs[w.r_fmt.rd] = a & b;
            fn_or:   regs[w.r_fmt.rd] = a | b;
            fn_slt:  regs[w.r_fmt.rd] = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            default: ;
          endcase
        end
        op_addiu: regs[w.i_fmt.rt] = adr;
        op_lw:    regs[w.i_fmt.rt] = mem[adr[8:2]];
        op_sw: begin
          mem[adr[8:2]] = b;
          exp_addr.push_back(adr);
          exp_data.push_back(b);
        end
        op_beq: if (a == b) pc += int'($signed(w.i_fmt.imm));
        default: ;
      endcase
      regs[0] = '0;
      steps++;
      if (steps > 1000) abort_run("model did not reach the end of the program");
    end
  endtask

  // bus slave and monitor, sampled mid-cycle
  always @(negedge clk) begin
    ack_next = 1'b0;
    if (!rst_n) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] = fill_word(i);
      end
      acc_open = 1'b0;
      pend     = 1'b0;
    end else begin
      if (!run && (wb_cyc || wb_stb)) abort_run("bus cycle started before run");
      if (pend) begin  // access still open, request must not move
        if (!(wb_cyc && wb_stb)) abort_run("wb_stb dropped before wb_ack");
        if (wb_we !== pend_we) abort_run("wb_we changed before wb_ack");
        check_addr(pend_adr, wb_adr);
        check_data(pend_dat, wb_dat_w);
      end
      if (wb_cyc && wb_stb && wb_ack && wb_we) begin
        if (store_cnt >= exp_addr.size()) abort_run("store beyond the expected sequence");
        check_addr(exp_addr[store_cnt], wb_adr);
        check_data(exp_data[store_cnt], wb_dat_w);
        store_cnt++;
      end
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!acc_open) begin
          acc_open = 1'b1;
          ack_wait = $urandom_range(0, 3);
        end
        if (ack_wait == 0) begin
          ack_next   = 1'b1;
          rdata_next = dmem[wb_adr[8:2]];
          if (wb_we) dmem[wb_adr[8:2]] = wb_dat_w;
          acc_open   = 1'b0;
        end else begin
          ack_wait--;
        end
      end
      pend     = wb_cyc && wb_stb && !wb_ack;
      pend_we  = wb_we;
      pend_adr = wb_adr;
      pend_dat = wb_dat_w;
    end
  end

  always @(posedge clk) begin
    wb_ack   <= ack_next;
    wb_dat_r <= rdata_next;
  end

  initial begin
    int cycles;
    void'($urandom(32'h68d5_800c));
    rst_n     <= 1'b0;
    run       <= 1'b0;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    gen_program();
    run_model();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < imem_depth; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= addr_bits'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    run <= 1'b1;
    cycles = 0;
    while (store_cnt < exp_addr.size()) begin
      @(posedge clk);
      cycles++;
      if (cycles > 5000) abort_run("timeout waiting for the expected stores");
    end
    $display("Test passed");
    $finish;
  end
endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core #(
  parameter int imem_depth = 256
) (
  input  logic clk, rst_n, run, prog_we,
  input  logic [$clog2(imem_depth)-1:0] prog_addr,
  input  logic [mips_pkg::data_width-1:0] prog_data,
  input  logic [mips_pkg::data_width-1:0] wb_dat_r,
  input  logic wb_ack,
  output logic wb_cyc, wb_stb, wb_we,
  output logic [mips_pkg::data_width-1:0] wb_adr, wb_dat_w
);
  import mips_pkg::*;

  logic hold, stall, flush, branch_taken, mem_busy;
  logic [1:0] fwd_a, fwd_b;
  logic [data_width-1:0] branch_target;

  // fetch and decode
  logic [data_width-1:0] pc_f, instr_f, pc_d, instr_d, imm_d, rd1_d, rd2_d;
  logic [reg_addr_width-1:0] rs_d, rt_d, dest_d;
  alu_op_t alu_op_d;
  logic alu_src_d, mem_read_d, mem_write_d, branch_d, reg_write_d;

  // execute
  logic [data_width-1:0] pc_e, imm_e, rd1_e, rd2_e, alu_result_e, store_data_e;
  logic [reg_addr_width-1:0] rs_e, rt_e, dest_e;
  alu_op_t alu_op_e;
  logic alu_src_e, mem_read_e, mem_write_e, branch_e, reg_write_e;

  // memory and write-back
  logic [data_width-1:0] alu_result_m, store_data_m, result_m, result_w;
  logic [reg_addr_width-1:0] dest_m, dest_w;
  logic mem_read_m, mem_write_m, reg_write_m, reg_write_w;

  fetch_unit #(.imem_depth(imem_depth)) u_fetch (
    .clk, .rst_n, .run, .hold, .stall, .branch_taken, .branch_target,
    .prog_we, .prog_addr, .prog_data, .pc(pc_f), .instr(instr_f)
  );

  if_id_register u_if_id (
    .clk, .rst_n, .hold, .stall, .flush,
    .instr_in(instr_f), .pc_in(pc_f), .instr_out(instr_d), .pc_out(pc_d)
  );

  decoder u_decoder (
    .instr(instr_d), .rs(rs_d), .rt(rt_d), .dest(dest_d), .immediate(imm_d),
    .alu_op(alu_op_d), .alu_src(alu_src_d), .mem_read(mem_read_d),
    .mem_write(mem_write_d), .branch(branch_d), .reg_write(reg_write_d)
  );

  reg_file u_reg_file (
    .clk, .rst_n, .rs(rs_d), .rt(rt_d),
    .wr_en(reg_write_w), .wr_addr(dest_w), .wr_data(result_w),
    .read_data_1(rd1_d), .read_data_2(rd2_d)
  );

  id_ex_register u_id_ex (
    .clk, .rst_n, .hold, .stall, .flush,
    .rs_in(rs_d), .rt_in(rt_d), .rd_in(dest_d),
    .read_data_1_in(rd1_d), .read_data_2_in(rd2_d), .immediate_in(imm_d), .pc_in(pc_d),
    .alu_op_in(alu_op_d), .alu_src_in(alu_src_d), .mem_read_in(mem_read_d),
    .mem_write_in(mem_write_d), .branch_in(branch_d), .reg_write_in(reg_write_d),
    .rs_out(rs_e), .rt_out(rt_e), .rd_out(dest_e),
    .read_data_1_out(rd1_e), .read_data_2_out(rd2_e), .immediate_out(imm_e), .pc_out(pc_e),
    .alu_op_out(alu_op_e), .alu_src_out(alu_src_e), .mem_read_out(mem_read_e),
    .mem_write_out(mem_write_e), .branch_out(branch_e), .reg_write_out(reg_write_e)
  );

  hazard_unit u_hazard (
    .id_rs(rs_d), .id_rt(rt_d), .ex_dest(dest_e), .ex_mem_read(mem_read_e),
    .ex_reg_write(reg_write_e), .mem_dest(dest_m), .mem_reg_write(reg_write_m),
    .wb_dest(dest_w), .wb_reg_write(reg_write_w), .ex_rs(rs_e), .ex_rt(rt_e),
    .branch_taken, .mem_busy, .fwd_a, .fwd_b, .stall, .flush, .hold
  );

  alu u_alu (
    .rs_value(rd1_e), .rt_value(rd2_e), .fwd_a, .fwd_b,
    .mem_value(alu_result_m), .wb_value(result_w), .immediate(imm_e),
    .alu_op(alu_op_e), .alu_src(alu_src_e), .branch(branch_e), .pc(pc_e),
    .alu_result(alu_result_e), .store_data(store_data_e), .branch_taken, .branch_target
  );

  ex_mem_register u_ex_mem (
    .clk, .rst_n, .hold,
    .alu_result_in(alu_result_e), .store_data_in(store_data_e), .dest_in(dest_e),
    .mem_read_in(mem_read_e), .mem_write_in(mem_write_e), .reg_write_in(reg_write_e),
    .alu_result_out(alu_result_m), .store_data_out(store_data_m), .dest_out(dest_m),
    .mem_read_out(mem_read_m), .mem_write_out(mem_write_m), .reg_write_out(reg_write_m)
  );

  wb_data_master u_wb_master (
    .clk, .rst_n, .alu_result(alu_result_m), .store_data(store_data_m),
    .mem_read(mem_read_m), .mem_write(mem_write_m), .wb_dat_r, .wb_ack,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .mem_busy, .result(result_m)
  );

  mem_wb_register u_mem_wb (
    .clk, .rst_n, .hold,
    .result_in(result_m), .dest_in(dest_m), .reg_write_in(reg_write_m),
    .result_out(result_w), .dest_out(dest_w), .reg_write_out(reg_write_w)
  );
endmodule

// File: wb_data_master.sv
`timescale 1ns/1ps

module wb_data_master (
  input  logic clk, rst_n,
  input  logic [mips_pkg::data_width-1:0] alu_result, store_data,
  input  logic mem_read, mem_write,
  input  logic [mips_pkg::data_width-1:0] wb_dat_r,
  input  logic wb_ack,
  output logic wb_cyc, wb_stb, wb_we,
  output logic [mips_pkg::data_width-1:0] wb_adr, wb_dat_w,
  output logic mem_busy,
  output logic [mips_pkg::data_width-1:0] result
);
  logic active;  // 0 idle, 1 cycle on the bus
  logic mem_op;

  assign mem_op = mem_read || mem_write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else if (active) begin
      active <= !wb_ack;  // release the bus the cycle after ack
    end else begin
      active <= mem_op;
    end
  end

  // address and data come straight from ex_mem, which stays frozen until ack
  assign wb_cyc   = active;
  assign wb_stb   = active;
  assign wb_we    = active && mem_write;
  assign wb_adr   = alu_result;
  assign wb_dat_w = store_data;

  assign mem_busy = mem_op && !(active && wb_ack);
  assign result   = mem_read ? wb_dat_r : alu_result;
endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [mips_pkg::data_width-1:0] rs_value, rt_value,
  input  logic [1:0] fwd_a, fwd_b,
  input  logic [mips_pkg::data_width-1:0] mem_value, wb_value, immediate,
  input  mips_pkg::alu_op_t alu_op,
  input  logic alu_src, branch,
  input  logic [mips_pkg::data_width-1:0] pc,
  output logic [mips_pkg::data_width-1:0] alu_result, store_data,
  output logic branch_taken,
  output logic [mips_pkg::data_width-1:0] branch_target
);
  import mips_pkg::*;

  logic [data_width-1:0] op_a, op_b;

  function automatic logic [data_width-1:0] pick(input logic [1:0] sel,
                                                 input logic [data_width-1:0] reg_value);
    case (sel)
      2'b10:   return mem_value;
      2'b01:   return wb_value;
      default: return reg_value;
    endcase
  endfunction

  always_comb begin
    op_a       = pick(fwd_a, rs_value);
    store_data = pick(fwd_b, rt_value);
    op_b       = alu_src ? immediate : store_data;
    case (alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  assign branch_taken  = branch && (op_a == store_data);
  assign branch_target = pc + 32'd4 + {immediate[data_width-3:0], 2'b00};
endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic [mips_pkg::reg_addr_width-1:0] id_rs, id_rt,
  input  logic [mips_pkg::reg_addr_width-1:0] ex_dest,
  input  logic ex_mem_read, ex_reg_write,
  input  logic [mips_pkg::reg_addr_width-1:0] mem_dest,
  input  logic mem_reg_write,
  input  logic [mips_pkg::reg_addr_width-1:0] wb_dest,
  input  logic wb_reg_write,
  input  logic [mips_pkg::reg_addr_width-1:0] ex_rs, ex_rt,
  input  logic branch_taken, mem_busy,
  output logic [1:0] fwd_a, fwd_b,
  output logic stall, flush, hold
);
  import mips_pkg::*;

  // 2'b10 memory stage, 2'b01 write-back stage, 2'b00 register file
  function automatic logic [1:0] fwd_sel(input logic [reg_addr_width-1:0] src);
    if (mem_reg_write && mem_dest != '0 && mem_dest == src) return 2'b10;
    if (wb_reg_write && wb_dest != '0 && wb_dest == src) return 2'b01;
    return 2'b00;
  endfunction

  always_comb begin
    fwd_a = fwd_sel(ex_rs);
    fwd_b = fwd_sel(ex_rt);
  end

  assign stall = ex_mem_read && ex_reg_write && ex_dest != '0 &&
                 (ex_dest == id_rs || ex_dest == id_rt);
  assign flush = branch_taken;
  assign hold  = mem_busy;  // bus wait freezes every stage
endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic clk, rst_n,
  input  logic [mips_pkg::reg_addr_width-1:0] rs, rt,
  input  logic wr_en,
  input  logic [mips_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [mips_pkg::data_width-1:0] wr_data,
  output logic [mips_pkg::data_width-1:0] read_data_1, read_data_2
);
  import mips_pkg::*;

  logic [data_width-1:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) return '0;
    if (wr_en && addr == wr_addr) return wr_data;  // write-through for the wb stage
    return regs[addr];
  endfunction

  always_comb begin
    read_data_1 = read_reg(rs);
    read_data_2 = read_reg(rt);
  end
endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
  input  mips_pkg::instr_t instr,
  output logic [mips_pkg::reg_addr_width-1:0] rs, rt, dest,
  output logic [mips_pkg::data_width-1:0] immediate,
  output mips_pkg::alu_op_t alu_op,
  output logic alu_src, mem_read, mem_write, branch, reg_write
);
  import mips_pkg::*;

  always_comb begin
    rs        = instr.i_fmt.rs;
    rt        = instr.i_fmt.rt;
    dest      = instr.i_fmt.rt;
    immediate = {{(data_width-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
    alu_op    = alu_add;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    reg_write = 1'b0;
    case (instr.i_fmt.opcode)
      op_special: begin
        dest      = instr.r_fmt.rd;
        reg_write = 1'b1;
        case (instr.r_fmt.funct)
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_slt:  alu_op = alu_slt;
          default: reg_write = 1'b0;  // unsupported function is a no-op
        endcase
      end
      op_addiu: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_lw: begin
        alu_src   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      op_sw: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      op_beq:  branch = 1'b1;  // compare done in execute
      default: ;
    endcase
  end
endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int imem_depth = 256
) (
  input  logic clk, rst_n, run, hold, stall, branch_taken,
  input  logic [mips_pkg::data_width-1:0] branch_target,
  input  logic prog_we,
  input  logic [$clog2(imem_depth)-1:0] prog_addr,
  input  logic [mips_pkg::data_width-1:0] prog_data,
  output logic [mips_pkg::data_width-1:0] pc,
  output logic [mips_pkg::data_width-1:0] instr
);
  import mips_pkg::*;

  localparam int addr_bits = $clog2(imem_depth);

  logic [data_width-1:0] imem [imem_depth];

  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;  // start from word 0 once run rises
    end else if (!hold) begin
      if (branch_taken) begin
        pc <= branch_target;
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  assign instr = run ? imem[pc[addr_bits+1:2]] : '0;
endmodule

// File: stage_regs.sv
`timescale 1ns/1ps

module if_id_register (
  input  logic clk, rst_n, hold, stall, flush,
  input  logic [mips_pkg::data_width-1:0] instr_in, pc_in,
  output logic [mips_pkg::data_width-1:0] instr_out, pc_out
);
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_out <= '0;
      pc_out    <= '0;
    end else if (!hold) begin
      if (flush) begin
        instr_out <= '0;  // all-zero word decodes as a no-op
        pc_out    <= '0;
      end else if (!stall) begin
        instr_out <= instr_in;
        pc_out    <= pc_in;
      end
    end
  end
endmodule

module id_ex_register (
  input  logic clk, rst_n, hold, stall, flush,
  input  logic [mips_pkg::reg_addr_width-1:0] rs_in, rt_in, rd_in,
  input  logic [mips_pkg::data_width-1:0] read_data_1_in, read_data_2_in,
  input  logic [mips_pkg::data_width-1:0] immediate_in, pc_in,
  input  mips_pkg::alu_op_t alu_op_in,
  input  logic alu_src_in, mem_read_in, mem_write_in, branch_in, reg_write_in,
  output logic [mips_pkg::reg_addr_width-1:0] rs_out, rt_out, rd_out,
  output logic [mips_pkg::data_width-1:0] read_data_1_out, read_data_2_out,
  output logic [mips_pkg::data_width-1:0] immediate_out, pc_out,
  output mips_pkg::alu_op_t alu_op_out,
  output logic alu_src_out, mem_read_out, mem_write_out, branch_out, reg_write_out
);
  import mips_pkg::*;

  logic bubble;

  assign bubble = stall || flush;  // load-use gap or squashed branch shadow

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {rs_out, rt_out, rd_out} <= '0;
      {read_data_1_out, read_data_2_out, immediate_out, pc_out} <= '0;
      {alu_src_out, mem_read_out, mem_write_out, branch_out, reg_write_out} <= '0;
      alu_op_out <= alu_add;
    end else if (!hold) begin
      if (bubble) begin
        {rs_out, rt_out, rd_out} <= '0;
        {read_data_1_out, read_data_2_out, immediate_out, pc_out} <= '0;
        {alu_src_out, mem_read_out, mem_write_out, branch_out, reg_write_out} <= '0;
        alu_op_out <= alu_add;
      end else begin
        {rs_out, rt_out, rd_out} <= {rs_in, rt_in, rd_in};
        {read_data_1_out, read_data_2_out, immediate_out, pc_out} <=
          {read_data_1_in, read_data_2_in, immediate_in, pc_in};
        {alu_src_out, mem_read_out, mem_write_out, branch_out, reg_write_out} <=
          {alu_src_in, mem_read_in, mem_write_in, branch_in, reg_write_in};
        alu_op_out <= alu_op_in;
      end
    end
  end
endmodule

module ex_mem_register (
  input  logic clk, rst_n, hold,
  input  logic [mips_pkg::data_width-1:0] alu_result_in, store_data_in,
  input  logic [mips_pkg::reg_addr_width-1:0] dest_in,
  input  logic mem_read_in, mem_write_in, reg_write_in,
  output logic [mips_pkg::data_width-1:0] alu_result_out, store_data_out,
  output logic [mips_pkg::reg_addr_width-1:0] dest_out,
  output logic mem_read_out, mem_write_out, reg_write_out
);
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {alu_result_out, store_data_out, dest_out} <= '0;
      {mem_read_out, mem_write_out, reg_write_out} <= '0;
    end else if (!hold) begin
      {alu_result_out, store_data_out, dest_out} <= {alu_result_in, store_data_in, dest_in};
      {mem_read_out, mem_write_out, reg_write_out} <= {mem_read_in, mem_write_in, reg_write_in};
    end
  end
endmodule

module mem_wb_register (
  input  logic clk, rst_n, hold,
  input  logic [mips_pkg::data_width-1:0] result_in,
  input  logic [mips_pkg::reg_addr_width-1:0] dest_in,
  input  logic reg_write_in,
  output logic [mips_pkg::data_width-1:0] result_out,
  output logic [mips_pkg::reg_addr_width-1:0] dest_out,
  output logic reg_write_out
);
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_out    <= '0;
      dest_out      <= '0;
      reg_write_out <= 1'b0;
    end else if (!hold) begin
      result_out    <= result_in;
      dest_out      <= dest_in;
      reg_write_out <= reg_write_in;
    end
  end
endmodule

// File: mips_pkg.sv
package mips_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_beq     = 6'h04,
    op_addiu   = 6'h09,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_slt  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [4:0]                shamt;
    funct_t                    funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [15:0]               imm;
  } i_fmt_t;

  // same 32 bits, seen as either format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_t;

endpackage
